// ==== Bender.yml ====
package:
  name: mem_ctrl

sources:
  - files:
      - rtl/memPkg.sv
      - rtl/memArbiter.sv
      - rtl/byteSequencer.sv
      - rtl/wordAssembler.sv
      - rtl/memCtrl.sv

  - target: test
    files:
      - tests/memCtrl_checker.sv
      - tests/memCtrlTb.sv

// ==== filelist.f ====
rtl/memPkg.sv
rtl/memArbiter.sv
rtl/byteSequencer.sv
rtl/wordAssembler.sv
rtl/memCtrl.sv
tests/memCtrl_checker.sv
tests/memCtrlTb.sv

// ==== rtl/byteSequencer.sv ====
module byteSequencer
    import memPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  ioBufferFull,

    input  logic                  grantValid,
    input  logic                  grantStore,
    input  logic [lenWidth-1:0]   grantLen,
    input  logic [addrWidth-1:0]  grantAddr,
    input  logic [wordWidth-1:0]  grantWdata,

    output logic [addrWidth-1:0]  memAddr,
    output logic                  memWrite,
    output logic [byteWidth-1:0]  memDout,

    output logic                  readStrobe,
    output logic [laneBits-1:0]   readLane,
    output logic                  accessEnd
);

    logic                  stall;
    logic [stageWidth-1:0] stage;
    logic [stageWidth-1:0] lastStage;
    logic [stageWidth-1:0] addrStage;
    logic                  holdRead;

    assign stall = !rdy || ioBufferFull;

    // a store ends on its last write, a read one cycle after its last address
    assign lastStage = grantStore ? stageWidth'(grantLen) - 1'b1 : stageWidth'(grantLen);

    assign accessEnd = grantValid && !stall && (stage == lastStage);

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else if (grantValid && !stall) begin
            if (accessEnd) begin
                stage <= '0;
            end else begin
                stage <= stage + 1'b1;
            end
        end
    end

    // a stalled read reissues the previous address,
    // so memDin still carries the byte owed to the current lane
    assign holdRead = stall && !grantStore && (stage != '0);
    assign addrStage = holdRead ? stage - 1'b1 : stage;

    assign memAddr = grantAddr + addrWidth'(addrStage);

    // no write strobe while frozen
    assign memWrite = grantValid && grantStore && !stall;

    // little-endian byte for this stage
    assign memDout = grantWdata[byteWidth*stage[laneBits-1:0] +: byteWidth];

    // byte issued in the previous stage is on memDin now
    assign readStrobe = grantValid && !grantStore && !stall && (stage != '0);
    assign readLane = laneBits'(stage - 1'b1);

endmodule

// ==== rtl/memArbiter.sv ====
module memArbiter
    import memPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  fetchEn,
    input  logic [addrWidth-1:0]  fetchAddr,

    input  logic                  dataEn,
    input  logic                  dataStore,
    input  logic [lenWidth-1:0]   dataLen,
    input  logic [addrWidth-1:0]  dataAddr,
    input  logic [wordWidth-1:0]  dataWdata,

    input  logic                  accessEnd,

    output logic                  grantValid,
    output logic [ownerWidth-1:0] grantOwner,
    output logic                  grantStore,
    output logic [lenWidth-1:0]   grantLen,
    output logic [addrWidth-1:0]  grantAddr,
    output logic [wordWidth-1:0]  grantWdata,

    output logic [ownerWidth-1:0] busyOwner
);

    logic startAccess;

    // only pick a new requester while nothing is in flight
    assign startAccess = !grantValid && (dataEn || fetchEn);

    always_ff @(posedge clk) begin
        if (rst) begin
            grantValid <= 1'b0;
            grantOwner <= ownerNone;
        end else if (grantValid) begin
            // locked until the sequencer finishes
            if (accessEnd) begin
                grantValid <= 1'b0;
            end
        end else if (startAccess) begin
            grantValid <= 1'b1;
            // data side wins a tie
            grantOwner <= dataEn ? ownerData : ownerFetch;
        end
    end

    // access description, captured with the grant
    always_ff @(posedge clk) begin
        if (startAccess) begin
            grantStore <= dataEn && dataStore;
            grantLen   <= dataEn ? dataLen : fetchLen;
            grantAddr  <= dataEn ? dataAddr : fetchAddr;
            grantWdata <= dataWdata;
        end
    end

    // core uses this to hold off the other unit
    assign busyOwner = grantValid ? grantOwner : ownerNone;

endmodule

// ==== rtl/memCtrl.sv ====
module memCtrl
    import memPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  ioBufferFull,

    // byte-wide RAM
    input  logic [byteWidth-1:0]  memDin,
    output logic                  memWrite,
    output logic [addrWidth-1:0]  memAddr,
    output logic [byteWidth-1:0]  memDout,

    output logic [ownerWidth-1:0] busyOwner,

    // instruction fetch
    input  logic                  fetchEn,
    input  logic [addrWidth-1:0]  fetchAddr,
    output logic                  fetchDone,
    output logic [wordWidth-1:0]  fetchInst,

    // data access
    input  logic                  dataEn,
    input  logic                  dataStore,
    input  logic [lenWidth-1:0]   dataLen,
    input  logic [addrWidth-1:0]  dataAddr,
    input  logic [wordWidth-1:0]  dataWdata,
    output logic                  dataDone,
    output logic [wordWidth-1:0]  dataRdata
);

    logic                  grantValid;
    logic [ownerWidth-1:0] grantOwner;
    logic                  grantStore;
    logic [lenWidth-1:0]   grantLen;
    logic [addrWidth-1:0]  grantAddr;
    logic [wordWidth-1:0]  grantWdata;

    logic                  readStrobe;
    logic [laneBits-1:0]   readLane;
    logic                  accessEnd;

    memArbiter arbiter (
        .clk        (clk),
        .rst        (rst),
        .fetchEn    (fetchEn),
        .fetchAddr  (fetchAddr),
        .dataEn     (dataEn),
        .dataStore  (dataStore),
        .dataLen    (dataLen),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .accessEnd  (accessEnd),
        .grantValid (grantValid),
        .grantOwner (grantOwner),
        .grantStore (grantStore),
        .grantLen   (grantLen),
        .grantAddr  (grantAddr),
        .grantWdata (grantWdata),
        .busyOwner  (busyOwner)
    );

    byteSequencer sequencer (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .grantValid   (grantValid),
        .grantStore   (grantStore),
        .grantLen     (grantLen),
        .grantAddr    (grantAddr),
        .grantWdata   (grantWdata),
        .memAddr      (memAddr),
        .memWrite     (memWrite),
        .memDout      (memDout),
        .readStrobe   (readStrobe),
        .readLane     (readLane),
        .accessEnd    (accessEnd)
    );

    wordAssembler assembler (
        .clk        (clk),
        .rst        (rst),
        .memDin     (memDin),
        .readStrobe (readStrobe),
        .readLane   (readLane),
        .accessEnd  (accessEnd),
        .grantOwner (grantOwner),
        .grantStore (grantStore),
        .grantLen   (grantLen),
        .fetchDone  (fetchDone),
        .fetchInst  (fetchInst),
        .dataDone   (dataDone),
        .dataRdata  (dataRdata)
    );

endmodule

// ==== rtl/memPkg.sv ====
package memPkg;

    // address and data path widths
    localparam int addrWidth = 32;
    localparam int wordWidth = 32;
    localparam int byteWidth = 8;

    // bytes per word and the lane index width
    localparam int laneCount = wordWidth / byteWidth;
    localparam int laneBits = $clog2(laneCount);

    // data length field, legal values 1, 2 and 4
    localparam int lenWidth = 3;

    // byte counter, must reach fetchLen
    localparam int stageWidth = 3;

    // instruction fetch always moves a full word
    localparam logic [lenWidth-1:0] fetchLen = 3'd4;

    // owner of the RAM
    localparam int ownerWidth = 2;
    localparam logic [ownerWidth-1:0] ownerNone = 2'd0;
    localparam logic [ownerWidth-1:0] ownerData = 2'd1;
    localparam logic [ownerWidth-1:0] ownerFetch = 2'd2;

    // one word seen either whole or as little-endian byte lanes
    // lane 0 is the least significant byte
    typedef union packed {
        logic [wordWidth-1:0] word;
        logic [laneCount-1:0][byteWidth-1:0] lanes;
    } byteLanes;

endpackage

// ==== rtl/wordAssembler.sv ====
module wordAssembler
    import memPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic [byteWidth-1:0]  memDin,
    input  logic                  readStrobe,
    input  logic [laneBits-1:0]   readLane,
    input  logic                  accessEnd,

    input  logic [ownerWidth-1:0] grantOwner,
    input  logic                  grantStore,
    input  logic [lenWidth-1:0]   grantLen,

    output logic                  fetchDone,
    output logic [wordWidth-1:0]  fetchInst,
    output logic                  dataDone,
    output logic [wordWidth-1:0]  dataRdata
);

    byteLanes captured;
    byteLanes merged;
    logic [wordWidth-1:0] loadWord;

    // lanes start from zero for every access
    always_ff @(posedge clk) begin
        if (rst || accessEnd) begin
            captured.word <= '0;
        end else if (readStrobe) begin
            captured.lanes[readLane] <= memDin;
        end
    end

    // last byte is still on memDin in the end cycle
    always_comb begin
        merged = captured;
        if (readStrobe) begin
            merged.lanes[readLane] = memDin;
        end
    end

    // zero extension, sign is the core's business
    always_comb begin
        loadWord = '0;
        case (grantLen)
            3'd1: begin
                loadWord[byteWidth-1:0] = merged.lanes[0];
            end
            3'd2: begin
                loadWord[2*byteWidth-1:0] = {merged.lanes[1], merged.lanes[0]};
            end
            default: begin
                loadWord = merged.word;
            end
        endcase
    end

    assign fetchDone = accessEnd && (grantOwner == ownerFetch);
    assign dataDone  = accessEnd && (grantOwner == ownerData);

    assign fetchInst = merged.word;
    // nothing to return for a store
    assign dataRdata = grantStore ? '0 : loadWord;

endmodule

// ==== tests/memCtrlTb.sv ====
module memCtrlTb
    import memPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriod = 40;
    localparam int driveDelay = 2;
    localparam int doneTimeout = 200;
    localparam int maxOps = 64;
    localparam int ramBytes = 256;

    logic                  clk;
    logic                  rst;
    logic                  rdy;
    logic                  ioBufferFull;
    logic [byteWidth-1:0]  memDin;
    logic                  memWrite;
    logic [addrWidth-1:0]  memAddr;
    logic [byteWidth-1:0]  memDout;
    logic [ownerWidth-1:0] busyOwner;
    logic                  fetchEn;
    logic [addrWidth-1:0]  fetchAddr;
    logic                  fetchDone;
    logic [wordWidth-1:0]  fetchInst;
    logic                  dataEn;
    logic                  dataStore;
    logic [lenWidth-1:0]   dataLen;
    logic [addrWidth-1:0]  dataAddr;
    logic [wordWidth-1:0]  dataWdata;
    logic                  dataDone;
    logic [wordWidth-1:0]  dataRdata;

    logic [byteWidth-1:0] ram [ramBytes];
    logic [byteWidth-1:0] shadow [ramBytes];

    // one entry per trace line
    logic [7:0]           opCode [maxOps];
    logic [addrWidth-1:0] opAddr [maxOps];
    logic [lenWidth-1:0]  opLen [maxOps];
    logic [wordWidth-1:0] opWdata [maxOps];
    logic [wordWidth-1:0] opExpect [maxOps];
    logic [addrWidth-1:0] opFetchAddr [maxOps];
    logic [wordWidth-1:0] opFetchExpect [maxOps];
    int opCount;

    logic [31:0] lfsr;
    logic stallsOn;
    logic timedOut;
    int mismatchCount;
    int timingCount;
    int timeoutCount;
    int otherCount;

    memCtrl dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic nextRandomBit();
        logic feedback;
        feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], feedback};
        return feedback;
    endfunction

    // rdy low about one cycle in four, buffer full about one in eight
    always @(posedge clk) begin : stallDriver
        logic b0;
        logic b1;
        logic b2;
        #(driveDelay);
        if (stallsOn) begin
            b0 = nextRandomBit();
            b1 = nextRandomBit();
            rdy = !(b0 && b1);
            b0 = nextRandomBit();
            b1 = nextRandomBit();
            b2 = nextRandomBit();
            ioBufferFull = b0 && b1 && b2;
        end else begin
            rdy = 1'b1;
            ioBufferFull = 1'b0;
        end
    end

    // byte RAM, data for the address of one cycle shows up in the next
    always @(posedge clk) begin : ramModel
        logic [7:0] readIndex;
        readIndex = memAddr[7:0];
        if (memWrite) begin
            ram[memAddr[7:0]] = memDout;
        end
        #(driveDelay);
        memDin = ram[readIndex];
    end

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("Mismatch %s: got %h expected %h", name, got, expected);
        mismatchCount++;
    endtask

    task automatic fillRam();
        int a;
        for (a = 0; a < ramBytes; a++) begin
            ram[a] = 8'(a) ^ 8'h5a;
            shadow[a] = ram[a];
        end
    endtask

    task automatic readTrace();
        int fd;
        int code;
        string line;
        logic [7:0] op;
        logic [31:0] fields [6];
        fd = $fopen("tests/memTrace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file tests/memTrace.txt");
            otherCount++;
            return;
        end
        while (!$feof(fd) && opCount < maxOps) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
                code = $sscanf(line, "%c %h %h %h %h %h %h", op, fields[0], fields[1],
                               fields[2], fields[3], fields[4], fields[5]);
                if (code == 7) begin
                    opCode[opCount] = op;
                    opAddr[opCount] = fields[0];
                    opLen[opCount] = fields[1][lenWidth-1:0];
                    opWdata[opCount] = fields[2];
                    opExpect[opCount] = fields[3];
                    opFetchAddr[opCount] = fields[4];
                    opFetchExpect[opCount] = fields[5];
                    opCount++;
                end else begin
                    $display("Badly formed trace line: %s", line);
                    otherCount++;
                end
            end
        end
        $fclose(fd);
    endtask

    // starts in the request cycle, returns at the falling edge of the done cycle
    task automatic waitForDone(input logic isFetch, input logic [ownerWidth-1:0] owner,
                               input int baseLatency);
        int cycles;
        int stalls;
        logic seen;
        cycles = 0;
        stalls = 0;
        seen = 1'b0;
        while (!seen && cycles < doneTimeout) begin
            @(negedge clk);
            cycles++;
            seen = isFetch ? fetchDone : dataDone;
            if (cycles == 1) begin
                if (busyOwner !== ownerNone) begin
                    reportMismatch("busyOwner", busyOwner, ownerNone);
                end
            end else begin
                if (busyOwner !== owner) begin
                    reportMismatch("busyOwner", busyOwner, owner);
                end
                if (!seen && (!rdy || ioBufferFull)) begin
                    stalls++;
                end
            end
        end
        if (!seen) begin
            $display("Timed out waiting for the %s done pulse", isFetch ? "fetch" : "data");
            timeoutCount++;
            timedOut = 1'b1;
        end else if (cycles - 1 != baseLatency + stalls) begin
            $display("The %s done pulse came %0d cycles after the request, expected %0d",
                     isFetch ? "fetch" : "data", cycles - 1, baseLatency + stalls);
            timingCount++;
        end
    endtask

    task automatic driveData(input int k, input logic store);
        dataEn = 1'b1;
        dataStore = store;
        dataLen = opLen[k];
        dataAddr = opAddr[k];
        dataWdata = opWdata[k];
    endtask

    task automatic compareRam();
        int a;
        for (a = 0; a < ramBytes; a++) begin
            if (ram[a] !== shadow[a]) begin
                reportMismatch($sformatf("ram[%h]", a[7:0]), ram[a], shadow[a]);
            end
        end
    endtask

    task automatic runOp(input int k);
        byteLanes lanes;
        int i;
        @(posedge clk);
        #(driveDelay);
        case (opCode[k])
            "F": begin
                fetchEn = 1'b1;
                fetchAddr = opFetchAddr[k];
                waitForDone(1'b1, ownerFetch, 5);
                if (!timedOut && fetchInst !== opFetchExpect[k]) begin
                    reportMismatch("fetchInst", fetchInst, opFetchExpect[k]);
                end
            end
            "L": begin
                driveData(k, 1'b0);
                waitForDone(1'b0, ownerData, 1 + int'(opLen[k]));
                if (!timedOut && dataRdata !== opExpect[k]) begin
                    reportMismatch("dataRdata", dataRdata, opExpect[k]);
                end
            end
            "S": begin
                lanes.word = opWdata[k];
                for (i = 0; i < int'(opLen[k]); i++) begin
                    shadow[8'(opAddr[k] + i)] = lanes.lanes[i];
                end
                driveData(k, 1'b1);
                waitForDone(1'b0, ownerData, int'(opLen[k]));
            end
            "B": begin
                // data must win, the fetch follows once the data side lets go
                fetchEn = 1'b1;
                fetchAddr = opFetchAddr[k];
                driveData(k, 1'b0);
                waitForDone(1'b0, ownerData, 1 + int'(opLen[k]));
                if (!timedOut && dataRdata !== opExpect[k]) begin
                    reportMismatch("dataRdata", dataRdata, opExpect[k]);
                end
                if (!timedOut) begin
                    @(posedge clk);
                    #(driveDelay);
                    dataEn = 1'b0;
                    waitForDone(1'b1, ownerFetch, 5);
                end
                if (!timedOut && fetchInst !== opFetchExpect[k]) begin
                    reportMismatch("fetchInst", fetchInst, opFetchExpect[k]);
                end
            end
            default: begin
                $display("Unknown operation code %c in trace line %0d", opCode[k], k);
                otherCount++;
            end
        endcase
        @(posedge clk);
        #(driveDelay);
        fetchEn = 1'b0;
        dataEn = 1'b0;
        if (opCode[k] == "S" && !timedOut) begin
            compareRam();
        end
    endtask

    initial begin
        int pass;
        int k;
        int assertFails;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        memDin = '0;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataStore = 1'b0;
        dataLen = '0;
        dataAddr = '0;
        dataWdata = '0;
        lfsr = 32'hf35a;
        stallsOn = 1'b0;
        timedOut = 1'b0;
        mismatchCount = 0;
        timingCount = 0;
        timeoutCount = 0;
        otherCount = 0;
        opCount = 0;
        fillRam();
        readTrace();
        if (opCount == 0) begin
            $display("The trace holds no operations");
            otherCount++;
        end

        repeat (4) @(posedge clk);
        #(driveDelay);
        rst = 1'b0;
        @(negedge clk);
        if (memWrite !== 1'b0) begin
            reportMismatch("memWrite", memWrite, 0);
        end
        if (fetchDone !== 1'b0 || dataDone !== 1'b0) begin
            reportMismatch("fetchDone,dataDone", {fetchDone, dataDone}, 0);
        end
        if (busyOwner !== ownerNone) begin
            reportMismatch("busyOwner", busyOwner, ownerNone);
        end

        // same trace twice, second time with random freezes
        for (pass = 0; pass < 2 && !timedOut; pass++) begin
            @(negedge clk);
            stallsOn = (pass == 1);
            fillRam();
            for (k = 0; k < opCount && !timedOut; k++) begin
                runOp(k);
            end
        end

        assertFails = dut.protocolCheck.failCount;
        $display("mismatches %0d, timing errors %0d, timeouts %0d, other errors %0d, %s %0d",
                 mismatchCount, timingCount, timeoutCount, otherCount,
                 "assertion failures", assertFails);
        if (mismatchCount + timingCount + timeoutCount + otherCount + assertFails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/memCtrl_checker.sv ====
module memCtrlChecker
    import memPkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  rdy,
    input logic                  ioBufferFull,
    input logic                  memWrite,
    input logic [ownerWidth-1:0] busyOwner,
    input logic                  fetchEn,
    input logic                  dataEn,
    input logic                  fetchDone,
    input logic                  dataDone
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;

    // frozen controller never strobes the RAM
    noWriteWhileFrozen: assert property (@(posedge clk) disable iff (rst)
        memWrite |-> (rdy && !ioBufferFull))
    else begin
        failCount++;
        $error("memWrite high while rdy low or ioBufferFull high");
    end

    oneDoneAtATime: assert property (@(posedge clk) disable iff (rst)
        !(fetchDone && dataDone))
    else begin
        failCount++;
        $error("fetchDone and dataDone high in the same cycle");
    end

    // a done pulse only answers a request that is still held
    noDoneWithoutRequest: assert property (@(posedge clk) disable iff (rst)
        !(fetchDone && !fetchEn) && !(dataDone && !dataEn))
    else begin
        failCount++;
        $error("done pulse without a pending request");
    end

    idleAfterReset: assert property (@(posedge clk)
        rst |=> (busyOwner == ownerNone && !memWrite))
    else begin
        failCount++;
        $error("controller not idle after reset");
    end

endmodule

bind memCtrl memCtrlChecker protocolCheck (.*);

// ==== tests/memTrace.txt ====
# op dataAddr len wdata dataExpect fetchAddr fetchExpect, all hex except op
# op: F fetch, L load, S store, B fetch and load requested together
F 00 0 00000000 00000000 00 59585b5a
F 00 0 00000000 00000000 40 19181b1a
L 10 1 00000000 0000004a 00 00000000
L 11 2 00000000 0000484b 00 00000000
L 20 4 00000000 79787b7a 00 00000000
L fc 4 00000000 a5a4a7a6 00 00000000
L c3 2 00000000 00009e99 00 00000000
S 30 4 deadbeef 00000000 00 00000000
L 30 4 00000000 deadbeef 00 00000000
S 34 1 12345678 00000000 00 00000000
L 34 4 00000000 6d6c6f78 00 00000000
S 36 2 cafe0b0c 00000000 00 00000000
L 34 4 00000000 0b0c6f78 00 00000000
L 33 1 00000000 000000de 00 00000000
B 80 4 00000000 d9d8dbda 90 c9c8cbca
B 85 1 00000000 000000df 30 deadbeef
S a1 2 00005566 00000000 00 00000000
L a0 4 00000000 f95566fa 00 00000000
F 00 0 00000000 00000000 34 0b0c6f78
L 86 2 00000000 0000dddc 00 00000000
S 04 4 0badf00d 00000000 00 00000000
F 00 0 00000000 00000000 04 0badf00d
